// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tb_fir -Mdir obj_dir
	./obj_dir/Vtb_fir | tee sim.log
	grep -q "Simulation finished: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// File: common/fir_pkg.sv
`include "fir_settings.svh"

package fir_pkg;

    // scalar widths
    typedef logic signed [`FIR_SAMPLE_W-1:0] sample_t;
    typedef logic signed [`FIR_ACC_W-1:0]    acc_t;

    // complex sample, real part in the upper half
    typedef struct packed {
        sample_t re;
        sample_t im;
    } cplx_sample_t;

    // complex accumulator value
    typedef struct packed {
        acc_t re;
        acc_t im;
    } cplx_acc_t;

    // input stream payload
    typedef struct packed {
        cplx_sample_t data;
        logic         last;   // final sample of a frame
    } in_beat_t;

    // output stream payload
    typedef struct packed {
        cplx_acc_t data;
        logic      last;      // final result of a frame
    } out_beat_t;

    typedef enum logic {
        SEQ_STREAM,           // taking samples
        SEQ_FLUSH             // pushing zeros and draining
    } seq_state_t;

endpackage

// File: common/fir_settings.svh
`ifndef FIR_SETTINGS_SVH
`define FIR_SETTINGS_SVH

// ======================================================================
// datapath widths
// ======================================================================
`define FIR_SAMPLE_W        16
`define FIR_ACC_W           (2 * `FIR_SAMPLE_W)

// ======================================================================
// filter shape and derived timing
// ======================================================================
`define FIR_TAPS            4                           // unique taps
`define FIR_TOTAL_TAPS      (2 * `FIR_TAPS - 1)         // odd symmetry
`define FIR_PIPE_DELAY      (`FIR_TAPS + 4)             // advance cycles, input to result
`define FIR_FLUSH_PUSHES    (`FIR_TOTAL_TAPS - 1)       // zeros after the last sample
`define FIR_FLUSH_CYCLES    (`FIR_FLUSH_PUSHES + `FIR_PIPE_DELAY)

// complex taps, outermost first, center tap last
`define FIR_COEF_RE_0       (-8)
`define FIR_COEF_RE_1       (22)
`define FIR_COEF_RE_2       (-50)
`define FIR_COEF_RE_3       (-20)
`define FIR_COEF_IM_0       (-33)
`define FIR_COEF_IM_1       (38)
`define FIR_COEF_IM_2       (-41)
`define FIR_COEF_IM_3       (-8)

`endif

// File: hdl/fir_top.sv
`timescale 1ns/1ns

module fir_top
    import fir_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      in_valid,
    output logic      in_ready,
    input  in_beat_t  in_beat,
    output logic      out_valid,
    output out_beat_t out_beat
);

    cplx_sample_t push_sample;
    cplx_sample_t mirror_sample;
    logic         advance;
    logic         push_valid;
    logic         push_last;
    cplx_acc_t    chain_result;

    // ==================================================================
    // input side
    // ==================================================================
    frame_sequencer u_frame_sequencer (
        .clk           (clk),
        .rst           (rst),
        .in_valid      (in_valid),
        .in_ready      (in_ready),
        .in_beat       (in_beat),
        .push_sample   (push_sample),
        .mirror_sample (mirror_sample),
        .advance       (advance),
        .push_valid    (push_valid),
        .push_last     (push_last)
    );

    // systolic taps
    tap_chain u_tap_chain (
        .clk           (clk),
        .rst           (rst),
        .advance       (advance),
        .push_sample   (push_sample),
        .mirror_sample (mirror_sample),
        .chain_result  (chain_result)
    );

    output_framer u_output_framer (
        .clk           (clk),
        .rst           (rst),
        .advance       (advance),
        .push_valid    (push_valid),
        .push_last     (push_last),
        .chain_result  (chain_result),
        .out_valid     (out_valid),
        .out_beat      (out_beat)
    );

endmodule

// File: hdl/frame_sequencer.sv
`timescale 1ns/1ns
`include "fir_settings.svh"

module frame_sequencer
    import fir_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         in_valid,
    output logic         in_ready,
    input  in_beat_t     in_beat,
    output cplx_sample_t push_sample,
    output cplx_sample_t mirror_sample,
    output logic         advance,
    output logic         push_valid,
    output logic         push_last
);

    localparam int MIRROR_TAP = `FIR_TOTAL_TAPS - 1;
    localparam int CNT_W      = $clog2(`FIR_FLUSH_CYCLES);

    seq_state_t       state;
    logic [CNT_W-1:0] flush_cnt;
    logic             accept;
    logic             flush_push;
    logic             flush_done;
    cplx_sample_t     delay_line [0:MIRROR_TAP];

    // ==================================================================
    // handshake and push control
    // ==================================================================
    assign in_ready   = (state == SEQ_STREAM);   // refuse only while flushing
    assign accept     = in_valid && in_ready;
    assign flush_push = (state == SEQ_FLUSH) && (flush_cnt < CNT_W'(`FIR_FLUSH_PUSHES));
    assign flush_done = (state == SEQ_FLUSH) && (flush_cnt == CNT_W'(`FIR_FLUSH_CYCLES - 1));

    assign advance     = accept || (state == SEQ_FLUSH);
    assign push_valid  = accept || flush_push;
    assign push_last   = (state == SEQ_FLUSH) && (flush_cnt == CNT_W'(`FIR_FLUSH_PUSHES - 1));
    assign push_sample = accept ? in_beat.data : '0;    // zeros during flush

    // frame state and flush counter
    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= SEQ_STREAM;
            flush_cnt <= '0;
        end else begin
            case (state)
                SEQ_STREAM: begin
                    flush_cnt <= '0;
                    if (accept && in_beat.last) begin
                        state <= SEQ_FLUSH;
                    end
                end
                SEQ_FLUSH: begin
                    if (flush_done) begin
                        state     <= SEQ_STREAM;
                        flush_cnt <= '0;
                    end else begin
                        flush_cnt <= flush_cnt + 1'b1;
                    end
                end
                default: begin
                    state     <= SEQ_STREAM;
                    flush_cnt <= '0;
                end
            endcase
        end
    end

    // ==================================================================
    // mirror delay line for the symmetric pre-add
    // ==================================================================
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i <= MIRROR_TAP; i++) begin
                delay_line[i] <= '0;
            end
        end else if (advance) begin
            delay_line[0] <= push_sample;
            for (int i = 1; i <= MIRROR_TAP; i++) begin
                delay_line[i] <= delay_line[i-1];
            end
        end
    end

    assign mirror_sample = delay_line[MIRROR_TAP];

    // a last beat blocks input for the whole flush, then ready returns
    a_flush_window: assert property (
        @(posedge clk) disable iff (rst)
        (accept && in_beat.last) |-> ##1 !in_ready ##(`FIR_FLUSH_CYCLES) in_ready
    );

endmodule

// File: hdl/output_framer.sv
`timescale 1ns/1ns
`include "fir_settings.svh"

module output_framer
    import fir_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      advance,
    input  logic      push_valid,
    input  logic      push_last,
    input  cplx_acc_t chain_result,
    output logic      out_valid,
    output out_beat_t out_beat
);

    localparam int DEPTH = `FIR_PIPE_DELAY;

    logic [DEPTH-1:0] valid_pipe;
    logic [DEPTH-1:0] last_pipe;

    // tags follow the chain, frozen along with it
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_pipe <= '0;
            last_pipe  <= '0;
        end else if (advance) begin
            valid_pipe <= {valid_pipe[DEPTH-2:0], push_valid};
            last_pipe  <= {last_pipe[DEPTH-2:0], push_last};
        end else begin
            valid_pipe[DEPTH-1] <= 1'b0;   // one pulse per result
            last_pipe[DEPTH-1]  <= 1'b0;
        end
    end

    assign out_valid = valid_pipe[DEPTH-1];
    assign out_beat  = '{data: chain_result, last: last_pipe[DEPTH-1]};

    a_last_has_valid: assert property (
        @(posedge clk) disable iff (rst)
        out_beat.last |-> out_valid
    );

endmodule

// File: tap_chain/systolic_tap.sv
`timescale 1ns/1ns
`include "fir_settings.svh"

module systolic_tap
    import fir_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         advance,
    input  cplx_sample_t coef,
    input  cplx_sample_t sample_in,
    input  cplx_sample_t mirror_in,
    input  cplx_acc_t    casc_in,
    output cplx_sample_t sample_out,
    output cplx_acc_t    casc_out
);

    // one bit of growth for the pre-add
    typedef logic signed [`FIR_SAMPLE_W:0] preadd_t;

    cplx_sample_t sample_d1;
    cplx_sample_t sample_d2;
    cplx_sample_t mirror_q;
    preadd_t      pre_re;
    preadd_t      pre_im;
    cplx_acc_t    mult_q;
    cplx_acc_t    casc_q;

    // ==================================================================
    // pre-add, complex multiply, cascade add
    // ==================================================================
    always_ff @(posedge clk) begin
        if (rst) begin
            sample_d1 <= '0;
            sample_d2 <= '0;
            mirror_q  <= '0;
            pre_re    <= '0;
            pre_im    <= '0;
            mult_q    <= '0;
            casc_q    <= '0;
        end else if (advance) begin
            sample_d1 <= sample_in;
            sample_d2 <= sample_d1;              // two stages per tap
            mirror_q  <= mirror_in;

            pre_re <= preadd_t'(sample_d2.re) + preadd_t'(mirror_q.re);
            pre_im <= preadd_t'(sample_d2.im) + preadd_t'(mirror_q.im);

            // four real products
            mult_q.re <= acc_t'(pre_re) * acc_t'(coef.re)
                       - acc_t'(pre_im) * acc_t'(coef.im);
            mult_q.im <= acc_t'(pre_re) * acc_t'(coef.im)
                       + acc_t'(pre_im) * acc_t'(coef.re);

            casc_q.re <= mult_q.re + casc_in.re;
            casc_q.im <= mult_q.im + casc_in.im;
        end
    end

    assign sample_out = sample_d2;
    assign casc_out   = casc_q;

    // cascade must stay clean once reset has released
    a_casc_known: assert property (
        @(posedge clk) disable iff (rst)
        !$isunknown(casc_out)
    );

endmodule

// File: tap_chain/tap_chain.sv
`timescale 1ns/1ns
`include "fir_settings.svh"

module tap_chain
    import fir_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         advance,
    input  cplx_sample_t push_sample,
    input  cplx_sample_t mirror_sample,
    output cplx_acc_t    chain_result
);

    localparam int TAPS = `FIR_TAPS;

    cplx_sample_t coef_tbl    [TAPS];
    cplx_sample_t sample_link [TAPS+1];   // last entry leaves the chain
    cplx_acc_t    casc_link   [TAPS+1];

    // coefficient table
    assign coef_tbl[0] = '{re: sample_t'(`FIR_COEF_RE_0), im: sample_t'(`FIR_COEF_IM_0)};
    assign coef_tbl[1] = '{re: sample_t'(`FIR_COEF_RE_1), im: sample_t'(`FIR_COEF_IM_1)};
    assign coef_tbl[2] = '{re: sample_t'(`FIR_COEF_RE_2), im: sample_t'(`FIR_COEF_IM_2)};
    assign coef_tbl[3] = '{re: sample_t'(`FIR_COEF_RE_3), im: sample_t'(`FIR_COEF_IM_3)};

    assign sample_link[0] = push_sample;
    assign casc_link[0]   = '0;           // chain starts from nothing

    for (genvar k = 0; k < TAPS; k++) begin : g_tap
        cplx_sample_t tap_mirror;

        // center tap of an odd filter has no partner
        assign tap_mirror = (k == TAPS - 1) ? '0 : mirror_sample;

        systolic_tap u_tap (
            .clk        (clk),
            .rst        (rst),
            .advance    (advance),
            .coef       (coef_tbl[k]),
            .sample_in  (sample_link[k]),
            .mirror_in  (tap_mirror),
            .casc_in    (casc_link[k]),
            .sample_out (sample_link[k+1]),
            .casc_out   (casc_link[k+1])
        );
    end

    assign chain_result = casc_link[TAPS];

endmodule

// File: tb.f
+incdir+common
common/fir_pkg.sv
hdl/frame_sequencer.sv
tap_chain/systolic_tap.sv
tap_chain/tap_chain.sv
hdl/output_framer.sv
hdl/fir_top.sv
testbench/tb_fir.sv

// File: testbench/tb_fir.sv
`timescale 1ns/1ns
`include "fir_settings.svh"

module tb_fir
    import fir_pkg::*;
;

    localparam int CLK_PERIOD   = 100;
    localparam int MAX_LEN      = 32;
    localparam int NUM_FRAMES   = 6;

    localparam int KIND_IMPULSE = 0;   // unit sample then zeros
    localparam int KIND_RANDOM  = 1;   // fresh xorshift data
    localparam int KIND_REPEAT  = 2;   // previous random data again

    // ======================================================================
    // stimulus table, one column per frame
    // ======================================================================
    // length, data kind, idle cycles before the frame, in_valid gap mask
    localparam int          FRAME_LEN      [NUM_FRAMES] = '{4, 12, 12, 1, 20, 5};
    localparam int          FRAME_KIND     [NUM_FRAMES] = '{KIND_IMPULSE, KIND_RANDOM,
                                                            KIND_REPEAT, KIND_RANDOM,
                                                            KIND_RANDOM, KIND_IMPULSE};
    localparam int          FRAME_LEAD     [NUM_FRAMES] = '{3, 2, 0, 0, 1, 0};
    localparam logic [7:0]  FRAME_GAP_MASK [NUM_FRAMES] = '{8'h00, 8'h00, 8'hb5,
                                                            8'h00, 8'h12, 8'hff};

    logic        clk;
    logic        rst;
    logic        in_valid;
    logic        in_ready;
    in_beat_t    in_beat;
    logic        out_valid;
    out_beat_t   out_beat;

    logic [31:0] rng_state;
    int          error_count;
    int          frame_results;
    sample_t     frame_re [MAX_LEN];
    sample_t     frame_im [MAX_LEN];
    longint      exp_re   [$];
    longint      exp_im   [$];
    longint      exp_last [$];

    fir_top fir_top_i (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_beat   (in_beat),
        .out_valid (out_valid),
        .out_beat  (out_beat)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ======================================================================
    // failure handling and checks
    // ======================================================================
    task automatic abort_run(input string why);
        error_count++;
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_value(input string name, input longint got, input longint exp);
        if (got != exp) begin
            abort_run($sformatf("mismatch at %0t ns: %s is %0d, expected %0d",
                                $time, name, got, exp));
        end
    endtask

    // ======================================================================
    // reference model
    // ======================================================================
    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // full symmetric response, index 0..6
    function automatic longint tap_re(input int i);
        int k;
        k = (i < `FIR_TAPS) ? i : `FIR_TOTAL_TAPS - 1 - i;
        case (k)
            0:       return `FIR_COEF_RE_0;
            1:       return `FIR_COEF_RE_1;
            2:       return `FIR_COEF_RE_2;
            default: return `FIR_COEF_RE_3;
        endcase
    endfunction

    function automatic longint tap_im(input int i);
        int k;
        k = (i < `FIR_TAPS) ? i : `FIR_TOTAL_TAPS - 1 - i;
        case (k)
            0:       return `FIR_COEF_IM_0;
            1:       return `FIR_COEF_IM_1;
            2:       return `FIR_COEF_IM_2;
            default: return `FIR_COEF_IM_3;
        endcase
    endfunction

    // direct linear convolution, zero history before the frame
    task automatic build_expected(input int len);
        longint acc_re;
        longint acc_im;
        longint xr;
        longint xi;
        int     q;
        for (int p = 0; p < len + `FIR_FLUSH_PUSHES; p++) begin
            acc_re = 0;
            acc_im = 0;
            for (int i = 0; i < `FIR_TOTAL_TAPS; i++) begin
                q = p - i;
                if (q >= 0 && q < len) begin
                    xr = frame_re[q];
                    xi = frame_im[q];
                    acc_re += xr * tap_re(i) - xi * tap_im(i);
                    acc_im += xr * tap_im(i) + xi * tap_re(i);
                end
            end
            exp_re.push_back(acc_re);
            exp_im.push_back(acc_im);
            exp_last.push_back((p == len + `FIR_FLUSH_PUSHES - 1) ? 1 : 0);
        end
    endtask

    task automatic fill_frame(input int kind, input int len);
        for (int i = 0; i < len; i++) begin
            if (kind == KIND_IMPULSE) begin
                frame_re[i] = (i == 0) ? sample_t'(1) : sample_t'(0);
                frame_im[i] = '0;
            end else if (kind == KIND_RANDOM) begin
                rng_state   = xorshift32(rng_state);
                frame_re[i] = sample_t'(rng_state[15:0]);
                frame_im[i] = sample_t'(rng_state[31:16]);
            end
        end
    endtask

    // ======================================================================
    // driver
    // ======================================================================
    // called at a falling edge, returns at the falling edge after acceptance
    task automatic drive_beat(input int idx, input logic last);
        in_valid          = 1'b1;
        in_beat.data.re   = frame_re[idx];
        in_beat.data.im   = frame_im[idx];
        in_beat.last      = last;
        while (!in_ready) begin
            @(negedge clk);   // hold the beat
        end
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic run_frame(input int f);
        int len;
        int low_cycles;
        len = FRAME_LEN[f];
        fill_frame(FRAME_KIND[f], len);
        build_expected(len);
        frame_results = 0;
        repeat (FRAME_LEAD[f]) @(negedge clk);
        for (int i = 0; i < len; i++) begin
            drive_beat(i, (i == len - 1));
            if (i < len - 1 && FRAME_GAP_MASK[f][i % 8]) begin
                repeat (1 + i % 3) @(negedge clk);   // idle in_valid
            end
        end
        low_cycles = 0;
        while (!in_ready) begin
            low_cycles++;
            @(negedge clk);
        end
        check_value("in_ready low cycles", low_cycles, `FIR_FLUSH_CYCLES);
        check_value("results per frame", frame_results, len + `FIR_FLUSH_PUSHES);
    endtask

    // in-order result monitor
    always @(negedge clk) begin
        if (!rst) begin
            if (out_valid) begin
                if (exp_re.size() == 0) begin
                    abort_run("out_valid seen with no result left to expect");
                end else begin
                    check_value("out_beat.data.re", out_beat.data.re, exp_re.pop_front());
                    check_value("out_beat.data.im", out_beat.data.im, exp_im.pop_front());
                    check_value("out_beat.last", out_beat.last, exp_last.pop_front());
                    frame_results++;
                end
            end else begin
                check_value("out_beat.last", out_beat.last, 0);
            end
        end
    end

    // ======================================================================
    // watchdog
    // ======================================================================
    function automatic longint watchdog_cycles();
        longint total;
        total = 20;   // reset and slack
        for (int f = 0; f < NUM_FRAMES; f++) begin
            total += FRAME_LEN[f] + FRAME_LEAD[f] + `FIR_FLUSH_CYCLES;
        end
        return total * 4;
    endfunction

    initial begin
        #(watchdog_cycles() * CLK_PERIOD);
        abort_run("timeout: the test sequence did not complete in time");
    end

    // main sequence
    initial begin
        rst         = 1'b1;
        in_valid    = 1'b0;
        in_beat     = '0;
        rng_state   = 32'd41;
        error_count = 0;
        frame_results = 0;
        repeat (10) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        check_value("in_ready", in_ready, 1);
        check_value("out_valid", out_valid, 0);
        check_value("out_beat.last", out_beat.last, 0);

        for (int f = 0; f < NUM_FRAMES; f++) begin
            run_frame(f);
        end

        if (error_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule
